// ==== rtl/mptw_pkg.sv ====
// Shared types and constants for the memory protection table walker
// Sized for a 34-bit SPA walked through two 11-bit index levels
// Table entries are 64 bits and memory is read-only from the walker's side

package mptw_pkg;

    //////////////////////////////
    // Address and entry widths
    //////////////////////////////

    localparam int unsigned SPA_WIDTH    = 34;
    localparam int unsigned PPN_WIDTH    = 22;
    localparam int unsigned INDEX_WIDTH  = 11;
    localparam int unsigned OFFSET_WIDTH = 12;
    localparam int unsigned MPTE_WIDTH   = 64;

    // Entry bit positions
    localparam int unsigned MPTE_V_BIT   = 0;
    localparam int unsigned MPTE_L_BIT   = 1;
    localparam int unsigned MPTE_R_BIT   = 2;
    localparam int unsigned MPTE_W_BIT   = 3;
    localparam int unsigned MPTE_X_BIT   = 4;
    // PPN field spans bits 31..10
    localparam int unsigned MPTE_PPN_LSB = 10;
    // Upper word is reserved, must read as zero
    localparam int unsigned MPTE_RSVD_LSB = MPTE_PPN_LSB + PPN_WIDTH;

    //////////////////////////////
    // Scalar types
    //////////////////////////////

    typedef logic [SPA_WIDTH-1:0] spa_t;
    typedef logic [PPN_WIDTH-1:0] ppn_t;

    // Table mode from the control register
    // Encodings 2 and 3 are reserved
    typedef enum logic [1:0] {
        MMPT_BARE = 2'd0,
        MMPT_34   = 2'd1
    } mmpt_mode_e;

    // Requested access kind
    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_EXEC  = 2'd2
    } access_e;

    // Format fault cause reported alongside the access fault
    typedef enum logic [1:0] {
        NO_ERROR      = 2'd0,
        MODE_RESERVED = 2'd1,
        MPTE_RESERVED = 2'd2
    } format_fault_e;

    //////////////////////////////
    // Pipeline transaction
    //////////////////////////////

    // Carried unchanged in shape through every stage
    typedef struct packed {
        spa_t          spa;
        access_e       access;
        // Table base for the next level to be walked
        ppn_t          base_ppn;
        // Set once a result is known, later stages then skip it
        logic          completed;
        logic          perm_r;
        logic          perm_w;
        logic          perm_x;
        logic          access_fault;
        format_fault_e format_error;
    } mptw_txn_t;

endpackage : mptw_pkg

// ==== rtl/mptw_fetch_stage.sv ====
// Entry stage of the walker, one transaction deep
// Only MMPT_34 needs walking; other modes complete here

module mptw_fetch_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    // Request side
    input  mptw_pkg::spa_t         spa_i,
    input  mptw_pkg::mmpt_mode_e   mode_i,
    input  mptw_pkg::ppn_t         root_ppn_i,
    input  mptw_pkg::access_e      access_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    // Towards the first walking stage
    output logic                   valid_o,
    input  logic                   ready_i,
    output mptw_pkg::mptw_txn_t    txn_o
);

    import mptw_pkg::*;

    logic      valid_q;
    mptw_txn_t txn_q;
    mptw_txn_t txn_new;

    // Free slot, or the held one leaves this cycle
    assign ready_o = !valid_q || ready_i;

    // Build the transaction from the request
    always_comb begin
        txn_new              = '0;
        txn_new.spa          = spa_i;
        txn_new.access       = access_i;
        txn_new.base_ppn     = root_ppn_i;
        txn_new.format_error = NO_ERROR;
        case (mode_i)
            MMPT_BARE: begin
                // No protection, everything allowed
                txn_new.completed = 1'b1;
                txn_new.perm_r    = 1'b1;
                txn_new.perm_w    = 1'b1;
                txn_new.perm_x    = 1'b1;
            end
            MMPT_34: begin
                // Left for the walking stages
                txn_new.completed = 1'b0;
            end
            default: begin
                txn_new.completed    = 1'b1;
                txn_new.access_fault = 1'b1;
                txn_new.format_error = MODE_RESERVED;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            txn_q <= txn_new;
        end
    end

    assign valid_o = valid_q;
    assign txn_o   = txn_q;

    // Offer held until the walker takes it
    a_hold_offer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(txn_o));

endmodule : mptw_fetch_stage

// ==== rtl/mptw_walking_stage.sv ====
// One table level of the walk, holding a single transaction
// LEVEL 0 is the last (leaf) level, higher LEVEL walks closer to the root
// The index slice must fit inside the SPA, so LEVEL <= 1 with the default widths

module mptw_walking_stage #(
    parameter int unsigned LEVEL = 0
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    // Upstream link
    input  logic                              valid_i,
    output logic                              ready_o,
    input  mptw_pkg::mptw_txn_t               txn_i,
    // Downstream link
    output logic                              valid_o,
    input  logic                              ready_i,
    output mptw_pkg::mptw_txn_t               txn_o,
    // Table read port
    output logic                              mem_req_o,
    output mptw_pkg::spa_t                    mem_addr_o,
    input  logic                              mem_gnt_i,
    input  logic                              mem_valid_i,
    input  logic [mptw_pkg::MPTE_WIDTH-1:0]   mem_rdata_i,
    input  logic                              mem_error_i
);

    import mptw_pkg::*;

    // Lowest SPA bit of this level's index
    localparam int unsigned IDX_LSB = OFFSET_WIDTH + INDEX_WIDTH * LEVEL;
    localparam int unsigned PAD_W   = SPA_WIDTH - INDEX_WIDTH - 3;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_DONE
    } state_e;

    state_e                   state_q;
    state_e                   state_d;
    mptw_txn_t                txn_q;
    mptw_txn_t                txn_resp;
    logic                     accept;
    logic [INDEX_WIDTH-1:0]   index;
    logic                     entry_rsvd;

    //////////////////////////////
    // Link handshake
    //////////////////////////////

    // Take a new one when empty or while the held result drains
    assign ready_o = (state_q == ST_IDLE) || (state_q == ST_DONE && ready_i);
    assign accept  = valid_i && ready_o;
    assign valid_o = (state_q == ST_DONE);
    assign txn_o   = txn_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_REQ: begin
                if (mem_gnt_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (mem_valid_i) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                if (ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
        // Completed work skips memory entirely
        if (accept) begin
            state_d = txn_i.completed ? ST_DONE : ST_REQ;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // Entry address
    //////////////////////////////

    assign index      = txn_q.spa[IDX_LSB +: INDEX_WIDTH];
    // Table base plus 8 bytes per entry
    assign mem_addr_o = {txn_q.base_ppn, {OFFSET_WIDTH{1'b0}}}
                      + {{PAD_W{1'b0}}, index, 3'b000};
    assign mem_req_o  = (state_q == ST_REQ);

    //////////////////////////////
    // Entry decode
    //////////////////////////////

    assign entry_rsvd = |mem_rdata_i[MPTE_WIDTH-1:MPTE_RSVD_LSB];

    // Checks in priority order
    always_comb begin
        txn_resp = txn_q;
        if (mem_error_i || !mem_rdata_i[MPTE_V_BIT]) begin
            txn_resp.completed    = 1'b1;
            txn_resp.access_fault = 1'b1;
        end else if (entry_rsvd || (!mem_rdata_i[MPTE_L_BIT] && LEVEL == 0)) begin
            // Pointer on the leaf level is malformed too
            txn_resp.completed    = 1'b1;
            txn_resp.access_fault = 1'b1;
            txn_resp.format_error = MPTE_RESERVED;
        end else if (mem_rdata_i[MPTE_L_BIT]) begin
            txn_resp.completed = 1'b1;
            txn_resp.perm_r    = mem_rdata_i[MPTE_R_BIT];
            txn_resp.perm_w    = mem_rdata_i[MPTE_W_BIT];
            txn_resp.perm_x    = mem_rdata_i[MPTE_X_BIT];
        end else begin
            // Next level table
            txn_resp.base_ppn = mem_rdata_i[MPTE_PPN_LSB +: PPN_WIDTH];
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            txn_q <= txn_i;
        end else if (state_q == ST_WAIT && mem_valid_i) begin
            txn_q <= txn_resp;
        end
    end

    //////////////////////////////
    // Memory protocol checks
    //////////////////////////////

    a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o));

    // Response only for the one outstanding read
    a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_valid_i |-> state_q == ST_WAIT);

endmodule : mptw_walking_stage

// ==== rtl/mptw_parsing_stage.sv ====
// Final permission check, never stalls its upstream
// Every incoming transaction must already be completed

module mptw_parsing_stage (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      valid_i,
    output logic                      ready_o,
    input  mptw_pkg::mptw_txn_t       txn_i,
    // Result, valid for one cycle per transaction
    output logic                      valid_o,
    output logic                      access_page_fault_o,
    output mptw_pkg::format_fault_e   format_error_o
);

    import mptw_pkg::*;

    logic          valid_q;
    logic          fault_q;
    logic          fault_d;
    logic          perm_ok;
    format_fault_e format_q;

    assign ready_o = 1'b1;

    // Permission bit matching the requested access
    always_comb begin
        case (txn_i.access)
            ACC_READ:  perm_ok = txn_i.perm_r;
            ACC_WRITE: perm_ok = txn_i.perm_w;
            ACC_EXEC:  perm_ok = txn_i.perm_x;
            default:   perm_ok = 1'b0;
        endcase
    end

    assign fault_d = txn_i.access_fault || !perm_ok;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            fault_q  <= fault_d;
            format_q <= txn_i.format_error;
        end
    end

    assign valid_o             = valid_q;
    assign access_page_fault_o = fault_q;
    assign format_error_o      = format_q;

    // Last walking level always resolves the walk
    a_arrives_completed: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i |-> txn_i.completed);

endmodule : mptw_parsing_stage

// ==== rtl/mptw_top.sv ====
// Memory protection table walker, results leave in input order
// One read port per walking stage; NUM_LEVELS must match the SPA layout (2 by default)
// Output side has no back-pressure

module mptw_top #(
    parameter int unsigned NUM_LEVELS = 2
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    // Request
    input  mptw_pkg::spa_t                    spa_i,
    input  mptw_pkg::mmpt_mode_e              mmpt_mode_i,
    input  mptw_pkg::ppn_t                    mmpt_ppn_i,
    input  mptw_pkg::access_e                 access_type_i,
    input  logic                              mptw_valid_i,
    output logic                              mptw_ready_o,
    // Result
    output logic                              mptw_valid_o,
    output logic                              access_page_fault_o,
    output mptw_pkg::format_fault_e           format_error_o,
    // Table read ports, one per level
    output logic                              mem_req_o   [NUM_LEVELS],
    output mptw_pkg::spa_t                    mem_addr_o  [NUM_LEVELS],
    input  logic                              mem_gnt_i   [NUM_LEVELS],
    input  logic                              mem_valid_i [NUM_LEVELS],
    input  logic [mptw_pkg::MPTE_WIDTH-1:0]   mem_rdata_i [NUM_LEVELS],
    input  logic                              mem_error_i [NUM_LEVELS]
);

    import mptw_pkg::*;

    // Link k feeds walking stage k, the last link feeds the parser
    logic      link_valid [NUM_LEVELS+1];
    logic      link_ready [NUM_LEVELS+1];
    mptw_txn_t link_txn   [NUM_LEVELS+1];

    //////////////////////////////
    // Fetch
    //////////////////////////////

    mptw_fetch_stage u_fetch (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .spa_i      (spa_i),
        .mode_i     (mmpt_mode_i),
        .root_ppn_i (mmpt_ppn_i),
        .access_i   (access_type_i),
        .valid_i    (mptw_valid_i),
        .ready_o    (mptw_ready_o),
        .valid_o    (link_valid[0]),
        .ready_i    (link_ready[0]),
        .txn_o      (link_txn[0])
    );

    //////////////////////////////
    // Walk, root level first
    //////////////////////////////

    for (genvar i = 0; i < NUM_LEVELS; i++) begin : gen_walk
        mptw_walking_stage #(
            .LEVEL (NUM_LEVELS - 1 - i)
        ) u_walk (
            .clk_i       (clk_i),
            .arst_n_i    (arst_n_i),
            .valid_i     (link_valid[i]),
            .ready_o     (link_ready[i]),
            .txn_i       (link_txn[i]),
            .valid_o     (link_valid[i+1]),
            .ready_i     (link_ready[i+1]),
            .txn_o       (link_txn[i+1]),
            .mem_req_o   (mem_req_o[i]),
            .mem_addr_o  (mem_addr_o[i]),
            .mem_gnt_i   (mem_gnt_i[i]),
            .mem_valid_i (mem_valid_i[i]),
            .mem_rdata_i (mem_rdata_i[i]),
            .mem_error_i (mem_error_i[i])
        );
    end

    //////////////////////////////
    // Parse
    //////////////////////////////

    // Parser always accepts
    assign link_ready[NUM_LEVELS] = 1'b1;

    mptw_parsing_stage u_parse (
        .clk_i               (clk_i),
        .arst_n_i            (arst_n_i),
        .valid_i             (link_valid[NUM_LEVELS]),
        .ready_o             (),
        .txn_i               (link_txn[NUM_LEVELS]),
        .valid_o             (mptw_valid_o),
        .access_page_fault_o (access_page_fault_o),
        .format_error_o      (format_error_o)
    );

endmodule : mptw_top

// ==== sim/tb_mptw_mem_model.sv ====
// Table memory behind the walker's read ports, one server process per port
// Entries never loaded read as zero (V = 0), marked addresses answer with an error
// Grant and response each wait 0 to 3 cycles, drawn from the shared $urandom stream

module tb_mptw_mem_model #(
    parameter int unsigned NUM_PORTS = 2
) (
    input  logic                              clk_i,
    input  logic                              mem_req_i   [NUM_PORTS],
    input  mptw_pkg::spa_t                    mem_addr_i  [NUM_PORTS],
    output logic                              mem_gnt_o   [NUM_PORTS],
    output logic                              mem_valid_o [NUM_PORTS],
    output logic [mptw_pkg::MPTE_WIDTH-1:0]   mem_rdata_o [NUM_PORTS],
    output logic                              mem_error_o [NUM_PORTS]
);

    timeunit 1ns;
    timeprecision 1ps;

    import mptw_pkg::*;

    // Table contents and failing addresses, filled by the testbench
    logic [MPTE_WIDTH-1:0] entries  [spa_t];
    bit                    bad_addr [spa_t];

    task automatic load_entry(input spa_t addr, input logic [MPTE_WIDTH-1:0] data);
        entries[addr] = data;
    endtask

    task automatic mark_bad(input spa_t addr);
        bad_addr[addr] = 1'b1;
    endtask

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
        logic                  gnt_q;
        logic                  valid_q;
        logic [MPTE_WIDTH-1:0] rdata_q;
        logic                  error_q;

        assign mem_gnt_o[p]   = gnt_q;
        assign mem_valid_o[p] = valid_q;
        assign mem_rdata_o[p] = rdata_q;
        assign mem_error_o[p] = error_q;

        // Serves one read at a time, outputs change 1 ns after the edge
        initial begin : server
            spa_t        addr;
            int unsigned delay;
            gnt_q   = 1'b0;
            valid_q = 1'b0;
            rdata_q = '0;
            error_q = 1'b0;
            forever begin
                @(posedge clk_i);
                #1;
                if (mem_req_i[p]) begin
                    addr  = mem_addr_i[p];
                    // Request is held, so the grant may lag
                    delay = $urandom_range(0, 3);
                    repeat (delay) begin
                        @(posedge clk_i);
                        #1;
                    end
                    gnt_q = 1'b1;
                    @(posedge clk_i);
                    #1;
                    gnt_q = 1'b0;
                    // Response never shares the grant cycle
                    delay = $urandom_range(0, 3);
                    repeat (delay) begin
                        @(posedge clk_i);
                        #1;
                    end
                    valid_q = 1'b1;
                    rdata_q = entries.exists(addr) ? entries[addr] : '0;
                    error_q = (bad_addr.exists(addr) != 0);
                    @(posedge clk_i);
                    #1;
                    valid_q = 1'b0;
                    error_q = 1'b0;
                end
            end
        end
    end

endmodule : tb_mptw_mem_model

// ==== sim/tb_mptw_top.sv ====
// Directed tests for the table walker against a table memory with random latency
// Two levels only, root table at ROOT_PPN, table loaded once before reset release
// Results are checked in issue order against a model of the walk rules

module tb_mptw_top;

    timeunit 1ns;
    timeprecision 1ps;

    import mptw_pkg::*;

    localparam int unsigned NUM_LEVELS = 2;
    localparam ppn_t        ROOT_PPN   = 22'h000100;
    // Two second-level tables
    localparam ppn_t        L2A_PPN    = 22'h000200;
    localparam ppn_t        L2B_PPN    = 22'h000300;

    typedef struct packed {
        logic          fault;
        format_fault_e fmt;
    } result_t;

    logic          clk;
    logic          arst_n;
    spa_t          spa;
    mmpt_mode_e    mode;
    ppn_t          root_ppn;
    access_e       access_type;
    logic          req_valid;
    logic          req_ready;
    logic          rsp_valid;
    logic          rsp_fault;
    format_fault_e rsp_format;

    logic                  mem_req   [NUM_LEVELS];
    spa_t                  mem_addr  [NUM_LEVELS];
    logic                  mem_gnt   [NUM_LEVELS];
    logic                  mem_valid [NUM_LEVELS];
    logic [MPTE_WIDTH-1:0] mem_rdata [NUM_LEVELS];
    logic                  mem_error [NUM_LEVELS];

    // Copy of what the memory model holds
    logic [MPTE_WIDTH-1:0] mem_image [spa_t];
    bit                    bad_addr  [spa_t];

    result_t               exp_q [$];
    // Ports that must stay quiet in the current test
    logic [NUM_LEVELS-1:0] forbid_req;
    int unsigned           issued;

    mptw_top #(
        .NUM_LEVELS (NUM_LEVELS)
    ) u_dut (
        .clk_i               (clk),
        .arst_n_i            (arst_n),
        .spa_i               (spa),
        .mmpt_mode_i         (mode),
        .mmpt_ppn_i          (root_ppn),
        .access_type_i       (access_type),
        .mptw_valid_i        (req_valid),
        .mptw_ready_o        (req_ready),
        .mptw_valid_o        (rsp_valid),
        .access_page_fault_o (rsp_fault),
        .format_error_o      (rsp_format),
        .mem_req_o           (mem_req),
        .mem_addr_o          (mem_addr),
        .mem_gnt_i           (mem_gnt),
        .mem_valid_i         (mem_valid),
        .mem_rdata_i         (mem_rdata),
        .mem_error_i         (mem_error)
    );

    tb_mptw_mem_model #(
        .NUM_PORTS (NUM_LEVELS)
    ) u_mem (
        .clk_i       (clk),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_gnt_o   (mem_gnt),
        .mem_valid_o (mem_valid),
        .mem_rdata_o (mem_rdata),
        .mem_error_o (mem_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Failure and compare
    //////////////////////////////

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_fault(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_format(input string name, input format_fault_e got,
                                input format_fault_e want);
        if (got !== want) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, want);
            stop_on_error();
        end
    endtask

    //////////////////////////////
    // Table building
    //////////////////////////////

    // Entry address with 8 bytes per index
    function automatic spa_t table_addr(input ppn_t base, input int unsigned idx);
        return {base, 12'h000} + (spa_t'(idx) << 3);
    endfunction

    function automatic logic [MPTE_WIDTH-1:0] ptr_entry(input ppn_t ppn);
        return {32'h0, ppn, 10'h001};
    endfunction

    function automatic logic [MPTE_WIDTH-1:0] leaf_entry(input logic r, input logic w,
                                                         input logic x);
        return {32'h0, 22'h0, 5'h0, x, w, r, 1'b1, 1'b1};
    endfunction

    function automatic spa_t make_spa(input int unsigned root_idx, input int unsigned l2_idx,
                                      input int unsigned off);
        return {11'(root_idx), 11'(l2_idx), 12'(off)};
    endfunction

    task automatic put_entry(input spa_t addr, input logic [MPTE_WIDTH-1:0] data);
        mem_image[addr] = data;
        u_mem.load_entry(addr, data);
    endtask

    task automatic put_bad(input spa_t addr);
        bad_addr[addr] = 1'b1;
        u_mem.mark_bad(addr);
    endtask

    task automatic load_table();
        // Root table with pointers, a leaf, a hole at 2, an error and reserved bits
        put_entry(table_addr(ROOT_PPN, 0), ptr_entry(L2A_PPN));
        put_entry(table_addr(ROOT_PPN, 1), leaf_entry(1'b1, 1'b0, 1'b1));
        put_entry(table_addr(ROOT_PPN, 3), ptr_entry(L2B_PPN));
        // Failing read over a leaf that would grant everything
        put_entry(table_addr(ROOT_PPN, 4), leaf_entry(1'b1, 1'b1, 1'b1));
        put_bad(table_addr(ROOT_PPN, 4));
        put_entry(table_addr(ROOT_PPN, 5), ptr_entry(L2B_PPN) | (64'h1 << 40));
        // Table A with two leaves, a last-level pointer, a hole, an error and a bad leaf
        put_entry(table_addr(L2A_PPN, 0), leaf_entry(1'b1, 1'b0, 1'b1));
        put_entry(table_addr(L2A_PPN, 1), leaf_entry(1'b1, 1'b1, 1'b0));
        put_entry(table_addr(L2A_PPN, 2), ptr_entry(L2B_PPN));
        put_entry(table_addr(L2A_PPN, 4), leaf_entry(1'b1, 1'b1, 1'b1));
        put_bad(table_addr(L2A_PPN, 4));
        put_entry(table_addr(L2A_PPN, 5), leaf_entry(1'b1, 1'b1, 1'b1) | (64'h1 << 63));
        // Table B
        put_entry(table_addr(L2B_PPN, 0), leaf_entry(1'b1, 1'b1, 1'b1));
        put_entry(table_addr(L2B_PPN, 1), leaf_entry(1'b0, 1'b1, 1'b0));
        put_entry(table_addr(L2B_PPN, 2), leaf_entry(1'b0, 1'b0, 1'b1));
    endtask

    //////////////////////////////
    // Reference walk
    //////////////////////////////

    function automatic result_t expect_result(input spa_t a, input mmpt_mode_e m,
                                              input ppn_t root, input access_e acc);
        result_t                res;
        ppn_t                   base;
        spa_t                   addr;
        logic [MPTE_WIDTH-1:0]  pte;
        logic [INDEX_WIDTH-1:0] idx;
        res.fault = 1'b1;
        res.fmt   = NO_ERROR;
        base      = root;
        if (m == MMPT_BARE) begin
            res.fault = 1'b0;
            return res;
        end
        if (m != MMPT_34) begin
            res.fmt = MODE_RESERVED;
            return res;
        end
        for (int lvl = 0; lvl < NUM_LEVELS; lvl++) begin
            idx  = (lvl == 0) ? a[33:23] : a[22:12];
            addr = table_addr(base, 32'(idx));
            pte  = mem_image.exists(addr) ? mem_image[addr] : '0;
            if (bad_addr.exists(addr) || !pte[MPTE_V_BIT]) begin
                return res;
            end
            if (|pte[63:32] || (!pte[MPTE_L_BIT] && lvl == NUM_LEVELS - 1)) begin
                res.fmt = MPTE_RESERVED;
                return res;
            end
            if (pte[MPTE_L_BIT]) begin
                case (acc)
                    ACC_READ:  res.fault = !pte[MPTE_R_BIT];
                    ACC_WRITE: res.fault = !pte[MPTE_W_BIT];
                    ACC_EXEC:  res.fault = !pte[MPTE_X_BIT];
                    default:   res.fault = 1'b1;
                endcase
                return res;
            end
            base = pte[31:10];
        end
        return res;
    endfunction

    //////////////////////////////
    // Driver
    //////////////////////////////

    // Called 1 ns after a rising edge, returns 1 ns after the transfer edge
    task automatic issue_request(input spa_t req_spa, input mmpt_mode_e req_mode,
                                 input access_e req_acc);
        exp_q.push_back(expect_result(req_spa, req_mode, ROOT_PPN, req_acc));
        issued++;
        spa         = req_spa;
        mode        = req_mode;
        root_ppn    = ROOT_PPN;
        access_type = req_acc;
        req_valid   = 1'b1;
        // Ready is settled mid-cycle
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_bare_mode();
        forbid_req = '1;
        for (int a = 0; a < 3; a++) begin
            issue_request(spa_t'($urandom), MMPT_BARE, access_e'(2'(a)));
        end
        wait_idle();
        forbid_req = '0;
    endtask

    task automatic test_reserved_modes();
        issue_request(make_spa(0, 0, 0), mmpt_mode_e'(2'd2), ACC_READ);
        issue_request(make_spa(0, 0, 4), mmpt_mode_e'(2'd3), ACC_EXEC);
        wait_idle();
    endtask

    task automatic test_two_level_walk();
        for (int a = 0; a < 3; a++) begin
            issue_request(make_spa(0, 0, 12'h10 * a), MMPT_34, access_e'(2'(a)));
        end
        wait_idle();
    endtask

    task automatic test_early_and_faults();
        // Root leaf, hole and error all stop before the second level
        forbid_req = 2'b10;
        for (int a = 0; a < 3; a++) begin
            issue_request(make_spa(1, a, 0), MMPT_34, access_e'(2'(a)));
        end
        issue_request(make_spa(2, 0, 0), MMPT_34, ACC_READ);
        issue_request(make_spa(4, 0, 0), MMPT_34, ACC_READ);
        wait_idle();
        forbid_req = '0;
        issue_request(make_spa(0, 3, 0), MMPT_34, ACC_READ);
        issue_request(make_spa(0, 4, 0), MMPT_34, ACC_EXEC);
        wait_idle();
    endtask

    task automatic test_malformed_entries();
        issue_request(make_spa(0, 2, 0), MMPT_34, ACC_READ);
        issue_request(make_spa(5, 0, 0), MMPT_34, ACC_READ);
        issue_request(make_spa(0, 5, 0), MMPT_34, ACC_WRITE);
        wait_idle();
    endtask

    task automatic test_random_stream();
        mmpt_mode_e m;
        for (int n = 0; n < 20; n++) begin
            if ($urandom_range(0, 9) == 0) begin
                m = MMPT_BARE;
            end else begin
                m = MMPT_34;
            end
            issue_request(make_spa($urandom_range(0, 5), $urandom_range(0, 5), $urandom),
                          m, access_e'(2'($urandom_range(0, 2))));
        end
        wait_idle();
    endtask

    //////////////////////////////
    // Monitor and watchdog
    //////////////////////////////

    always @(negedge clk) begin : monitor
        result_t want;
        for (int p = 0; p < NUM_LEVELS; p++) begin
            if (forbid_req[p] && mem_req[p]) begin
                $display("Memory request on port %0d where the walk must not read memory", p);
                stop_on_error();
            end
        end
        if (rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Result came out with no request outstanding");
                stop_on_error();
            end
            want = exp_q.pop_front();
            check_fault("access_page_fault_o", rsp_fault, want.fault);
            check_format("format_error_o", rsp_format, want.fmt);
        end
    end

    // Limit grows with every request issued
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < 2000 * (issued + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d results pending", cycles, exp_q.size());
        stop_on_error();
    end

    initial begin
        void'($urandom(10));
        arst_n      = 1'b0;
        spa         = '0;
        mode        = MMPT_BARE;
        root_ppn    = '0;
        access_type = ACC_READ;
        req_valid   = 1'b0;
        forbid_req  = '0;
        issued      = 0;
        load_table();
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_bare_mode();
        test_reserved_modes();
        test_two_level_walk();
        test_early_and_faults();
        test_malformed_entries();
        test_random_stream();
        if (exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d expected results never arrived", exp_q.size());
            stop_on_error();
        end
    end

endmodule : tb_mptw_top

// ==== mptw_top.f ====
rtl/mptw_pkg.sv
rtl/mptw_fetch_stage.sv
rtl/mptw_walking_stage.sv
rtl/mptw_parsing_stage.sv
rtl/mptw_top.sv
sim/tb_mptw_mem_model.sv
sim/tb_mptw_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the walker testbench with Verilator, result decided from sim.log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mptw_top -f mptw_top.f -o tb_mptw_top &&
./obj_dir/tb_mptw_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
